// File: switch_pkg.sv
package switch_pkg;

    // ----------------------------------------------------------------------
    // Fixed sizes
    // ----------------------------------------------------------------------
    localparam int NUM_PORTS = 4;           // Egress ports, fixed by register map

    typedef logic [7:0] byte_t;             // Data or address byte
    typedef logic [1:0] port_idx_t;         // Port number, also register address

    // ----------------------------------------------------------------------
    // Wishbone classic slave signals
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic      cyc;                     // Bus cycle in progress
        logic      stb;                     // Strobe, request valid
        logic      we;                      // Write enable
        port_idx_t adr;                     // Register select
        byte_t     dat;                     // Write data
    } wb_req_t;

    typedef struct packed {
        logic  ack;                         // One-cycle acknowledge
        byte_t dat;                         // Read data, valid with ack
    } wb_rsp_t;

    // FIFO word, payload byte tagged with end of packet
    typedef struct packed {
        logic  eop;
        byte_t data;
    } fifo_entry_t;

    // Egress port output
    typedef struct packed {
        logic  valid;                       // Head byte presented
        logic  last;                        // Final payload byte
        byte_t data;
    } port_out_t;

    // ----------------------------------------------------------------------
    // State encodings
    // ----------------------------------------------------------------------
    typedef enum logic {RT_IDLE, RT_PAYLOAD} router_state_e;

    typedef enum logic [1:0] {EG_IDLE, EG_SEND, EG_GAP} egress_state_e;

endpackage

// File: port_addr_regs.sv
module port_addr_regs
    import switch_pkg::*;
(
    input  logic    clk,
    input  logic    reset_b,
    // Wishbone slave
    input  wb_req_t i_wb,
    output wb_rsp_t o_wb,
    // Address table to router
    output byte_t   o_port_addr [NUM_PORTS]
);

    logic  ack_q;                           // Acknowledge register
    byte_t addr_q [NUM_PORTS];              // Port address table
    logic  req;                             // Active request this cycle

    assign req = i_wb.cyc && i_wb.stb;

    // ----------------------------------------------------------------------
    // Bus handshake
    // ----------------------------------------------------------------------

    // Ack one cycle after the request is seen, never two in a row
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req && !ack_q;
        end
    end

    assign o_wb.ack = ack_q;
    assign o_wb.dat = addr_q[i_wb.adr];     // Master holds adr through ack

    // ----------------------------------------------------------------------
    // Address registers
    // ----------------------------------------------------------------------

    // Reset to identity map, port k answers address k
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            for (int k = 0; k < NUM_PORTS; k++) begin
                addr_q[k] <= byte_t'(k);
            end
        end else if (ack_q && req && i_wb.we) begin
            addr_q[i_wb.adr] <= i_wb.dat;  // Write lands on the ack edge
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_PORTS; k++) begin
            o_port_addr[k] = addr_q[k];
        end
    end

    // Master holds its request unchanged until the ack
    assert property (@(posedge clk) disable iff (!reset_b)
        (req && !o_wb.ack) |=> $stable(i_wb))
        else $error("port_addr_regs: request changed before ack");

endmodule

// File: packet_router.sv
module packet_router
    import switch_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_b,
    // Ingress stream
    input  logic                 i_valid,
    input  byte_t                i_data,
    // Address table and FIFO levels
    input  byte_t                i_port_addr [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] i_almost_full,
    output logic                 o_stall,
    // FIFO write side
    output logic [NUM_PORTS-1:0] o_wr,
    output fifo_entry_t          o_entry
);

    router_state_e state_q;
    logic          hit_q;                   // Header matched a port
    port_idx_t     target_q;                // Resolved port for this packet
    logic          pend_q;                  // Byte waiting in data_q
    byte_t         data_q;                  // Payload byte, one cycle delay

    logic          match_hit;
    port_idx_t     match_idx;

    // ----------------------------------------------------------------------
    // Header match, lowest index wins
    // ----------------------------------------------------------------------
    always_comb begin
        match_hit = 1'b0;
        match_idx = '0;
        // Walk downward so the lowest match is the one left standing
        for (int k = NUM_PORTS - 1; k >= 0; k--) begin
            if (i_data == i_port_addr[k]) begin
                match_hit = 1'b1;
                match_idx = port_idx_t'(k);
            end
        end
    end

    // ----------------------------------------------------------------------
    // Ingress FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state_q  <= RT_IDLE;
            hit_q    <= 1'b0;
            target_q <= '0;
            pend_q   <= 1'b0;
        end else begin
            pend_q <= (state_q == RT_PAYLOAD) && i_valid && hit_q;
            case (state_q)
                RT_IDLE: begin
                    if (i_valid) begin      // Header byte, consumed here
                        state_q  <= RT_PAYLOAD;
                        hit_q    <= match_hit;
                        target_q <= match_idx;
                    end
                end
                RT_PAYLOAD: begin
                    if (!i_valid) state_q <= RT_IDLE;  // Gap ends the packet
                end
                default: state_q <= RT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        data_q <= i_data;                   // Byte written on the next edge
    end

    // Write one cycle late so the next i_valid tells us eop
    assign o_entry.eop  = !i_valid;
    assign o_entry.data = data_q;

    always_comb begin
        for (int k = 0; k < NUM_PORTS; k++) begin
            o_wr[k] = pend_q && (target_q == port_idx_t'(k));
        end
    end

    assign o_stall = |i_almost_full;        // Any port short of MAX_PKT space

    // Packets start only with MAX_PKT free everywhere, so no FIFO overflows
    assert property (@(posedge clk) disable iff (!reset_b)
        (state_q == RT_IDLE && i_valid) |-> !o_stall)
        else $error("packet_router: packet started under stall");

endmodule

// File: packet_fifo.sv
module packet_fifo
    import switch_pkg::*;
#(
    parameter int FIFO_DEPTH = 32,          // Power of two
    parameter int MAX_PKT    = 16
) (
    input  logic        clk,
    input  logic        reset_b,
    // Write side
    input  logic        i_wr,
    input  fifo_entry_t i_entry,
    // Read side, show-ahead
    input  logic        i_pop,
    output fifo_entry_t o_head,
    output logic        o_empty,
    output logic        o_almost_full
);

    localparam int AW = $clog2(FIFO_DEPTH);

    fifo_entry_t   mem [FIFO_DEPTH];
    logic [AW:0]   wptr_q;                  // Extra MSB is the wrap bit
    logic [AW:0]   rptr_q;
    logic [AW:0]   count;                   // Entries held
    logic          full;

    // ----------------------------------------------------------------------
    // Storage and pointers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_wr) mem[wptr_q[AW-1:0]] <= i_entry;
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            wptr_q <= '0;
            rptr_q <= '0;
        end else begin
            if (i_wr)  wptr_q <= wptr_q + 1'b1;
            if (i_pop) rptr_q <= rptr_q + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Flags
    // ----------------------------------------------------------------------
    assign count   = wptr_q - rptr_q;
    assign o_empty = (wptr_q == rptr_q);
    assign full    = (wptr_q[AW] != rptr_q[AW]) && (wptr_q[AW-1:0] == rptr_q[AW-1:0]);

    // Less than MAX_PKT free, i.e. a full packet might not fit
    assign o_almost_full = (count > (AW+1)'(FIFO_DEPTH - MAX_PKT));

    assign o_head = mem[rptr_q[AW-1:0]];    // Head visible right after write

    // Egress side must respect empty
    assert property (@(posedge clk) disable iff (!reset_b) i_pop |-> !o_empty)
        else $error("packet_fifo: pop while empty");

    // Router side relies on the stall to keep this
    assert property (@(posedge clk) disable iff (!reset_b) i_wr |-> !full)
        else $error("packet_fifo: write while full");

endmodule

// File: gap_timer.sv
module gap_timer #(
    parameter int GAP_CYCLES = 4            // At least 1
) (
    input  logic clk,
    input  logic reset_b,
    input  logic i_start,                   // Load on last byte of packet
    output logic o_done
);

    localparam int CW = $clog2(GAP_CYCLES + 1);

    logic [CW-1:0] cnt_q;                   // Zero when idle

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            cnt_q <= '0;
        end else if (i_start) begin
            cnt_q <= CW'(GAP_CYCLES);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // High in the final gap cycle, GAP_CYCLES after start
    assign o_done = (cnt_q == CW'(1));

endmodule

// File: egress_sm.sv
module egress_sm
    import switch_pkg::*;
(
    input  logic        clk,
    input  logic        reset_b,
    // FIFO side
    input  fifo_entry_t i_head,
    input  logic        i_empty,
    output logic        o_pop,
    // Port side
    input  logic        i_read,
    output port_out_t   o_port,
    // Gap timer
    input  logic        i_gap_done,
    output logic        o_start_gap
);

    egress_state_e state_q;
    logic          accept;                  // Byte taken this cycle

    // ----------------------------------------------------------------------
    // Port output
    // ----------------------------------------------------------------------

    // Head goes straight out except during the gap
    assign o_port.valid = (state_q != EG_GAP) && !i_empty;
    assign o_port.last  = o_port.valid && i_head.eop;
    assign o_port.data  = i_head.data;

    assign accept      = o_port.valid && i_read;
    assign o_pop       = accept;
    assign o_start_gap = accept && i_head.eop;   // Timer runs from this edge

    // ----------------------------------------------------------------------
    // Egress FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state_q <= EG_IDLE;
        end else begin
            case (state_q)
                EG_IDLE: begin
                    if (accept) begin
                        // Single-byte packet skips SEND
                        state_q <= i_head.eop ? EG_GAP : EG_SEND;
                    end
                end
                EG_SEND: begin
                    if (accept && i_head.eop) state_q <= EG_GAP;
                end
                EG_GAP: begin
                    if (i_gap_done) state_q <= EG_IDLE;  // Valid may return next
                end
                default: state_q <= EG_IDLE;
            endcase
        end
    end

    // Timer and FSM stay in step, done only seen while gapping
    assert property (@(posedge clk) disable iff (!reset_b)
        i_gap_done |-> (state_q == EG_GAP))
        else $error("egress_sm: gap done outside GAP state");

endmodule

// File: packet_switch.sv
module packet_switch
    import switch_pkg::*;
#(
    parameter int FIFO_DEPTH = 32,
    parameter int MAX_PKT    = 16,
    parameter int GAP_CYCLES = 4
) (
    input  logic                 clk,
    input  logic                 reset_b,
    // Register access
    input  wb_req_t              i_wb,
    output wb_rsp_t              o_wb,
    // Ingress
    input  logic                 i_valid,
    input  byte_t                i_data,
    output logic                 o_stall,
    // Egress
    output port_out_t            o_port [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] i_read
);

    byte_t                port_addr [NUM_PORTS];   // Address table
    logic [NUM_PORTS-1:0] fifo_wr;                 // Router write strobes
    fifo_entry_t          fifo_entry;              // Shared write word
    logic [NUM_PORTS-1:0] almost_full;
    fifo_entry_t          fifo_head [NUM_PORTS];
    logic [NUM_PORTS-1:0] fifo_empty;
    logic [NUM_PORTS-1:0] fifo_pop;
    logic [NUM_PORTS-1:0] gap_start;
    logic [NUM_PORTS-1:0] gap_done;

    // ----------------------------------------------------------------------
    // Shared blocks
    // ----------------------------------------------------------------------
    port_addr_regs u_regs (
        .clk         (clk),
        .reset_b     (reset_b),
        .i_wb        (i_wb),
        .o_wb        (o_wb),
        .o_port_addr (port_addr)
    );

    packet_router u_router (
        .clk           (clk),
        .reset_b       (reset_b),
        .i_valid       (i_valid),
        .i_data        (i_data),
        .i_port_addr   (port_addr),
        .i_almost_full (almost_full),
        .o_stall       (o_stall),
        .o_wr          (fifo_wr),
        .o_entry       (fifo_entry)
    );

    // ----------------------------------------------------------------------
    // Per-port lanes
    // ----------------------------------------------------------------------
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_lane
        packet_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .MAX_PKT(MAX_PKT)) u_fifo (
            .clk           (clk),
            .reset_b       (reset_b),
            .i_wr          (fifo_wr[p]),
            .i_entry       (fifo_entry),
            .i_pop         (fifo_pop[p]),
            .o_head        (fifo_head[p]),
            .o_empty       (fifo_empty[p]),
            .o_almost_full (almost_full[p])
        );

        egress_sm u_egress (
            .clk         (clk),
            .reset_b     (reset_b),
            .i_head      (fifo_head[p]),
            .i_empty     (fifo_empty[p]),
            .o_pop       (fifo_pop[p]),
            .i_read      (i_read[p]),
            .o_port      (o_port[p]),
            .i_gap_done  (gap_done[p]),
            .o_start_gap (gap_start[p])
        );

        gap_timer #(.GAP_CYCLES(GAP_CYCLES)) u_gap (
            .clk     (clk),
            .reset_b (reset_b),
            .i_start (gap_start[p]),
            .o_done  (gap_done[p])
        );
    end

endmodule

// File: tb_clock.sv
module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset_b
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Release on a falling edge, same as all other stimulus
    initial begin
        reset_b = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_b = 1'b1;
    end

endmodule

// File: packet_switch_tb.sv
module packet_switch_tb
    import switch_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FIFO_DEPTH  = 32;
    localparam int MAX_PKT     = 16;
    localparam int GAP_CYCLES  = 4;
    localparam int CLK_PERIOD  = 8;
    localparam int NUM_RAND    = 24;                    // Random packets in test 3
    localparam int TOTAL_BYTES = (NUM_RAND + 16) * MAX_PKT;  // Bound on payload sent
    localparam int WATCHDOG_CYCLES = (TOTAL_BYTES * GAP_CYCLES + 500) * 20;

    typedef enum {RD_LOW, RD_HIGH, RD_RANDOM} read_mode_e;

    logic                 clk;
    logic                 reset_b;
    wb_req_t              wb_req;
    wb_rsp_t              wb_rsp;
    logic                 in_valid;
    byte_t                in_data;
    logic                 stall;
    port_out_t            port_out [NUM_PORTS];
    logic [NUM_PORTS-1:0] port_read;

    byte_t       addr_model [NUM_PORTS];                // Address table as programmed
    fifo_entry_t exp_q [NUM_PORTS][$];                  // Expected bytes per port
    read_mode_e  read_mode [NUM_PORTS];
    int          gap_port = -1;                         // Port whose gaps get logged
    int          gap_log [$];
    logic [31:0] stim_lfsr = 32'ha5ee_8344;
    logic [31:0] read_lfsr = 32'ha5ee_8344;             // Separate stream for i_read
    string       cur_test = "reset";

    tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) u_clock (
        .clk     (clk),
        .reset_b (reset_b)
    );

    packet_switch #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .MAX_PKT    (MAX_PKT),
        .GAP_CYCLES (GAP_CYCLES)
    ) dut0 (
        .clk     (clk),
        .reset_b (reset_b),
        .i_wb    (wb_req),
        .o_wb    (wb_rsp),
        .i_valid (in_valid),
        .i_data  (in_data),
        .o_stall (stall),
        .o_port  (port_out),
        .i_read  (port_read)
    );

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'h8020_0003;     // Taps 32, 22, 2, 1
        else return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    // Lowest matching port, -1 when the packet is dropped
    function automatic int expected_port(input byte_t hdr, input byte_t addr_tbl [NUM_PORTS]);
        for (int k = 0; k < NUM_PORTS; k++) begin
            if (hdr == addr_tbl[k]) return k;
        end
        return -1;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_val(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error in %s, %s: expected 0x%0h, actual 0x%0h",
                     cur_test, what, expected, actual);
            stop_with_failure("Run stopped at the first mismatch");
        end
    endtask

    // ----------------------------------------------------------------------
    // Wishbone master
    // ----------------------------------------------------------------------
    task automatic wb_access(input logic we, input port_idx_t adr, input byte_t wdat,
                             output byte_t rdat);
        int waited;
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        waited = 0;
        @(negedge clk);
        while (!wb_rsp.ack) begin
            if (waited >= 8) stop_with_failure("Wishbone slave never acknowledged");
            else begin
                @(negedge clk);
                waited++;
            end
        end
        check_val("ack latency", 0, waited);            // Ack right after request
        rdat = wb_rsp.dat;
        @(negedge clk);
        check_val("ack width", 0, 32'(wb_rsp.ack));     // Exactly one cycle
        wb_req = '0;
    endtask

    task automatic wb_write(input port_idx_t adr, input byte_t dat);
        byte_t unused;
        wb_access(1'b1, adr, dat, unused);
        addr_model[adr] = dat;
    endtask

    task automatic wb_read_check(input port_idx_t adr, input byte_t expected);
        byte_t got;
        wb_access(1'b0, adr, 8'h00, got);
        check_val($sformatf("register %0d", adr), 32'(expected), 32'(got));
    endtask

    // ----------------------------------------------------------------------
    // Ingress source and drain
    // ----------------------------------------------------------------------

    // Header then len random payload bytes, started only without stall
    task automatic send_packet(input byte_t hdr, input int len);
        int          dest;
        byte_t       b;
        fifo_entry_t e;
        dest = expected_port(hdr, addr_model);
        @(negedge clk);
        while (stall) @(negedge clk);
        in_valid = 1'b1;
        in_data  = hdr;
        for (int i = 0; i < len; i++) begin
            @(negedge clk);
            b = byte_t'(take_bits(8));
            in_data = b;
            if (dest >= 0) begin
                e.eop  = (i == len - 1);
                e.data = b;
                exp_q[dest].push_back(e);
            end
        end
        @(negedge clk);
        in_valid = 1'b0;                                // Gap of at least one cycle
        in_data  = '0;
    endtask

    task automatic set_read(input int p, input read_mode_e mode);
        @(posedge clk);
        read_mode[p] = mode;
    endtask

    task automatic wait_drain();
        int pending;
        pending = 1;
        while (pending != 0) begin
            @(negedge clk);
            pending = 0;
            for (int p = 0; p < NUM_PORTS; p++) pending += exp_q[p].size();
        end
        repeat (GAP_CYCLES + 4) @(negedge clk);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_val($sformatf("port %0d valid when drained", p), 0,
                      32'(port_out[p].valid));
        end
    endtask

    // ----------------------------------------------------------------------
    // Egress reader and comparator
    // ----------------------------------------------------------------------
    initial begin : egress_monitor
        logic        rd;
        fifo_entry_t want;
        logic        gap_armed [NUM_PORTS];
        int          gap_cnt [NUM_PORTS];
        port_read = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            gap_armed[p] = 1'b0;
            gap_cnt[p]   = 0;
        end
        forever begin
            @(negedge clk);
            for (int p = 0; p < NUM_PORTS; p++) begin
                case (read_mode[p])
                    RD_LOW:  rd = 1'b0;
                    RD_HIGH: rd = 1'b1;
                    default: begin
                        read_lfsr = lfsr_next(read_lfsr);
                        rd = read_lfsr[0];
                    end
                endcase
                port_read[p] = rd;
                // Valid-low cycles since the last byte of a packet
                if (gap_armed[p] && port_out[p].valid) begin
                    gap_armed[p] = 1'b0;
                    if (p == gap_port) gap_log.push_back(gap_cnt[p]);
                end else if (gap_armed[p]) begin
                    gap_cnt[p]++;
                end
                if (port_out[p].valid && rd) begin      // Byte taken at next edge
                    if (exp_q[p].size() == 0) begin
                        stop_with_failure($sformatf(
                            "Port %0d put out byte 0x%0h with no packet for it",
                            p, port_out[p].data));
                    end else begin
                        want = exp_q[p].pop_front();
                        check_val($sformatf("port %0d data", p), 32'(want.data),
                                  32'(port_out[p].data));
                        check_val($sformatf("port %0d last", p), 32'(want.eop),
                                  32'(port_out[p].last));
                        if (want.eop) begin
                            gap_armed[p] = 1'b1;
                            gap_cnt[p]   = 0;
                        end
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_with_failure("Watchdog expired before the tests finished");
    end

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------
    initial begin : main
        byte_t hdr;
        int    pkts;
        wb_req   = '0;
        in_valid = 1'b0;
        in_data  = '0;
        for (int k = 0; k < NUM_PORTS; k++) begin
            addr_model[k] = byte_t'(k);                 // Reset map
            read_mode[k]  = RD_RANDOM;
        end
        @(posedge reset_b);

        cur_test = "reset_state";
        for (int p = 0; p < NUM_PORTS; p++) check_val("egress valid", 0, 32'(port_out[p].valid));
        check_val("stall", 0, 32'(stall));
        for (int k = 0; k < NUM_PORTS; k++) wb_read_check(port_idx_t'(k), byte_t'(k));

        cur_test = "addr_program";
        wb_write(2'd0, 8'h40);
        wb_write(2'd1, 8'h55);
        wb_write(2'd2, 8'h40);                          // Tie with port 0
        wb_write(2'd3, 8'h7e);
        for (int k = 0; k < NUM_PORTS; k++) wb_read_check(port_idx_t'(k), addr_model[k]);
        send_packet(8'h40, 5);
        send_packet(8'h55, 3);
        send_packet(8'h7e, 2);
        send_packet(8'h40, 1);
        wait_drain();
        wb_write(2'd2, 8'h6a);                          // Make all four reachable
        wb_read_check(2'd2, 8'h6a);

        cur_test = "random_traffic";
        for (int n = 0; n < NUM_RAND; n++) begin
            send_packet(addr_model[port_idx_t'(take_bits(2))], 1 + int'(take_bits(4)));
        end
        wait_drain();

        cur_test = "drop_unmatched";
        hdr = 8'hc3;
        while (expected_port(hdr, addr_model) >= 0) hdr = hdr + 8'd1;
        send_packet(hdr, MAX_PKT);
        for (int k = 0; k < NUM_PORTS; k++) send_packet(addr_model[k], 2 + k);
        send_packet(hdr, 1);
        send_packet(addr_model[3], 4);
        wait_drain();

        cur_test = "egress_gap";
        set_read(1, RD_LOW);
        send_packet(addr_model[1], 3);
        send_packet(addr_model[1], 5);
        @(posedge clk);
        gap_log.delete();
        gap_port     = 1;
        read_mode[1] = RD_HIGH;
        wait_drain();
        if (gap_log.size() == 0) stop_with_failure("No gap between packets seen on port 1");
        else check_val("gap cycles", GAP_CYCLES, gap_log[0]);
        gap_port = -1;

        cur_test = "stall_backpressure";
        set_read(2, RD_LOW);
        pkts = 0;
        while (!stall) begin
            if (pkts > FIFO_DEPTH / MAX_PKT) begin
                stop_with_failure("o_stall never rose while port 2 filled up");
            end else begin
                send_packet(addr_model[2], MAX_PKT);
                @(negedge clk);                         // Last byte now in the FIFO
                pkts++;
                check_val("stall level", 32'(exp_q[2].size() > FIFO_DEPTH - MAX_PKT),
                          32'(stall));
            end
        end
        set_read(2, RD_RANDOM);
        wait_drain();
        check_val("stall after drain", 0, 32'(stall));

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: packet_switch.f
switch_pkg.sv
port_addr_regs.sv
packet_router.sv
packet_fifo.sv
gap_timer.sv
egress_sm.sv
packet_switch.sv
tb_clock.sv
packet_switch_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := packet_switch_tb
FILELIST   := packet_switch.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status of the binary is the pass or fail result
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
